/* tb.f */
source/memctrl_pkg.sv
source/memctrl_if.sv
source/sram_1r1w.sv
source/replacement_plru.sv
source/tag_directory.sv
source/data_store.sv
source/rsp_combiner.sv
source/cache_memctrl.sv
verification/tb_cache_memctrl.sv

/* Bender.yml */
package:
  name: cache_memctrl

sources:
  - source/memctrl_pkg.sv
  - source/memctrl_if.sv
  - source/sram_1r1w.sv
  - source/replacement_plru.sv
  - source/tag_directory.sv
  - source/data_store.sv
  - source/rsp_combiner.sv
  - source/cache_memctrl.sv
  - target: test
    files:
      - verification/tb_cache_memctrl.sv

/* verification/tb_cache_memctrl.sv */
// Directed testbench for the cache controller with a tag, valid, MRU and data model
// Expected responses are taken from the model when a request is queued, in issue order

`timescale 1ns/1ps

module tb_cache_memctrl;
    import memctrl_pkg::*;

    localparam int HALF_PERIOD = 50;
    localparam int N_RANDOM    = 60;
    // Requests of all six tests with a read-back of at most four full sets
    localparam int TOTAL_REQS      = SETS + 5 + 4 + 9 + 4 + N_RANDOM + 4 * WAYS * LINE_WORDS;
    localparam int WATCHDOG_CYCLES = TOTAL_REQS * 20 + SETS + 10;

    typedef struct packed {
        op_t       op;
        set_t      set;
        tag_t      tag;
        word_idx_t word;
        word_t     wdata;
        be_t       be;
        way_idx_t  way;
        line_t     line;
    } req_t;

    typedef struct packed {
        logic     hit;
        way_vec_t way;
        word_t    rdata;
    } rsp_t;

    logic      clk_i;
    logic      rst_ni;
    logic      req_valid_i;
    op_t       req_op_i;
    set_t      req_set_i;
    tag_t      req_tag_i;
    word_idx_t req_word_i;
    word_t     req_wdata_i;
    be_t       req_be_i;
    way_idx_t  req_way_i;
    line_t     req_line_i;
    logic      req_ready_o;
    logic      rsp_valid_o;
    logic      rsp_hit_o;
    way_vec_t  rsp_way_o;
    word_t     rsp_rdata_o;
    logic      rsp_ready_i;

    req_t     req_q [$];
    rsp_t     exp_q [$];
    tag_t     m_tag   [SETS][WAYS];
    way_vec_t m_valid [SETS];
    way_vec_t m_mru   [SETS];
    word_t    m_data  [SETS][WAYS][LINE_WORDS];
    int       seed;
    int       err_count;
    int       check_count;
    int       test_count;

    cache_memctrl u_cache_memctrl (
        .clk_i,
        .rst_ni,
        .req_valid_i,
        .req_op_i,
        .req_set_i,
        .req_tag_i,
        .req_word_i,
        .req_wdata_i,
        .req_be_i,
        .req_way_i,
        .req_line_i,
        .req_ready_o,
        .rsp_valid_o,
        .rsp_hit_o,
        .rsp_way_o,
        .rsp_rdata_o,
        .rsp_ready_i
    );

    always #HALF_PERIOD clk_i = ~clk_i;

    // Mark the way and start over when every way would be marked
    function automatic way_vec_t mark_used(way_vec_t bits, way_vec_t way);
        way_vec_t next;
        next = bits | way;
        if (next == '1) begin
            next = way;
        end
        return next;
    endfunction

    function automatic way_vec_t pick_victim(set_t set);
        for (int w = 0; w < WAYS; w++) begin
            if (!m_valid[set][w]) begin
                return way_vec_t'(1) << w;
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            if (!m_mru[set][w]) begin
                return way_vec_t'(1) << w;
            end
        end
        return way_vec_t'(1);
    endfunction

    function automatic int find_way(set_t set, tag_t tag);
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[set][w] && (m_tag[set][w] == tag)) begin
                return w;
            end
        end
        return -1;
    endfunction

    function automatic line_t rand_line();
        line_t line;
        for (int j = 0; j < LINE_WORDS; j++) begin
            line[j] = word_t'($random(seed));
        end
        return line;
    endfunction

    // Queue one request and apply it to the model
    task automatic push_req(input op_t op, input set_t set, input tag_t tag,
                            input word_idx_t word, input word_t wdata, input be_t be,
                            input way_idx_t way, input line_t line);
        req_t r;
        rsp_t e;
        int   hw;
        r  = '{op, set, tag, word, wdata, be, way, line};
        e  = '0;
        hw = find_way(set, tag);
        if ((op == OP_READ || op == OP_WRITE) && hw >= 0) begin
            e.hit = 1'b1;
            e.way = way_vec_t'(1) << hw;
            if (op == OP_READ) begin
                e.rdata = m_data[set][hw][word];
            end else begin
                for (int b = 0; b < WORD_WIDTH / 8; b++) begin
                    if (be[b]) begin
                        m_data[set][hw][word][8*b +: 8] = wdata[8*b +: 8];
                    end
                end
            end
            m_mru[set] = mark_used(m_mru[set], e.way);
        end else if (op == OP_REFILL) begin
            e.way = pick_victim(set);
            for (int w = 0; w < WAYS; w++) begin
                if (e.way[w]) begin
                    m_tag[set][w] = tag;
                    for (int j = 0; j < LINE_WORDS; j++) begin
                        m_data[set][w][j] = line[j];
                    end
                end
            end
            m_valid[set] = m_valid[set] | e.way;
            m_mru[set]   = mark_used(m_mru[set], e.way);
        end else if (op == OP_INVAL) begin
            m_valid[set][way] = 1'b0;
            e.way = way_vec_t'(1) << way;
        end
        req_q.push_back(r);
        exp_q.push_back(e);
    endtask

    task automatic read_req(input set_t set, input tag_t tag, input word_idx_t word);
        push_req(OP_READ, set, tag, word, '0, '0, '0, '0);
    endtask

    task automatic write_req(input set_t set, input tag_t tag, input word_idx_t word,
                             input word_t wdata, input be_t be);
        push_req(OP_WRITE, set, tag, word, wdata, be, '0, '0);
    endtask

    task automatic refill_req(input set_t set, input tag_t tag, input line_t line);
        push_req(OP_REFILL, set, tag, '0, '0, '0, '0, line);
    endtask

    task automatic inval_req(input set_t set, input way_idx_t way);
        push_req(OP_INVAL, set, '0, '0, '0, '0, way, '0);
    endtask

    // Drive the queued requests and compare each response in order
    task automatic run_stream(input string name, input bit stall);
        int          sent;
        int          got;
        int          stall_left;
        logic [31:0] rnd;
        req_t        r;
        rsp_t        e;
        string       exp_str;
        string       act_str;
        sent       = 0;
        got        = 0;
        stall_left = 0;
        while (got < exp_q.size()) begin
            @(posedge clk_i);
            if (sent < req_q.size()) begin
                r = req_q[sent];
                req_valid_i <= 1'b1;
                req_op_i    <= r.op;
                req_set_i   <= r.set;
                req_tag_i   <= r.tag;
                req_word_i  <= r.word;
                req_wdata_i <= r.wdata;
                req_be_i    <= r.be;
                req_way_i   <= r.way;
                req_line_i  <= r.line;
            end else begin
                req_valid_i <= 1'b0;
            end
            if (stall) begin
                rnd = $random(seed);
                if (stall_left == 0 && rnd[1:0] == 2'b00) begin
                    stall_left = 1 + rnd[3:2];
                end
            end
            rsp_ready_i <= (stall_left == 0);
            if (stall_left > 0) begin
                stall_left--;
            end
            // Handshakes seen here complete on the next rising edge
            @(negedge clk_i);
            if (req_valid_i && req_ready_o) begin
                sent++;
            end
            if (rsp_valid_o && rsp_ready_i) begin
                e = exp_q[got];
                check_count++;
                if (rsp_hit_o !== e.hit || rsp_way_o !== e.way || rsp_rdata_o !== e.rdata) begin
                    exp_str = $sformatf("hit=%0b way=%b rdata=%h", e.hit, e.way, e.rdata);
                    act_str = $sformatf("hit=%0b way=%b rdata=%h",
                                        rsp_hit_o, rsp_way_o, rsp_rdata_o);
                    $display("** Error %s: response %0d expected %s, actual %s",
                             name, got, exp_str, act_str);
                    err_count++;
                end
                got++;
            end
        end
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        rsp_ready_i <= 1'b1;
        @(negedge clk_i);
        if (rsp_valid_o) begin
            $display("%s: a response appeared with no request left to answer", name);
            err_count++;
        end
        req_q.delete();
        exp_q.delete();
    endtask

    task automatic finish_test(input string name, input int start_err);
        test_count++;
        $display("%-16s done, %0d errors", name, err_count - start_err);
    endtask

    task automatic init_ready_miss();
        int start;
        int edges;
        start = err_count;
        edges = 0;
        do begin
            @(posedge clk_i);
            edges++;
            @(negedge clk_i);
        end while (!req_ready_o && edges < 4 * SETS);
        check_count++;
        if (edges != SETS) begin
            $display("** Error init_miss: ready after cycles expected %0d, actual %0d",
                     SETS, edges);
            err_count++;
        end
        for (int s = 0; s < SETS; s++) begin
            read_req(set_t'(s), tag_t'($random(seed)), word_idx_t'(s));
        end
        run_stream("init_miss", 1'b0);
        finish_test("init_miss", start);
    endtask

    task automatic line_fill_readback();
        int start;
        start = err_count;
        refill_req(4'd3, 20'h12345, rand_line());
        for (int j = 0; j < LINE_WORDS; j++) begin
            read_req(4'd3, 20'h12345, word_idx_t'(j));
        end
        run_stream("refill_read", 1'b0);
        finish_test("refill_read", start);
    endtask

    task automatic merge_write();
        int start;
        start = err_count;
        // Read right behind the write goes through the data bypass
        write_req(4'd3, 20'h12345, 2'd1, 32'hA5A5_5A5A, 4'b0101);
        read_req(4'd3, 20'h12345, 2'd1);
        write_req(4'd3, 20'h54321, 2'd2, 32'hFFFF_FFFF, 4'b1111);
        read_req(4'd3, 20'h12345, 2'd2);
        run_stream("write_merge", 1'b0);
        finish_test("write_merge", start);
    endtask

    task automatic victim_choice();
        int start;
        start = err_count;
        for (int w = 0; w < WAYS; w++) begin
            refill_req(4'd7, tag_t'(20'h100 + w), rand_line());
        end
        read_req(4'd7, 20'h102, 2'd0);
        read_req(4'd7, 20'h100, 2'd1);
        refill_req(4'd7, 20'h104, rand_line());
        read_req(4'd7, 20'h101, 2'd2);
        read_req(4'd7, 20'h104, 2'd3);
        run_stream("plru_victim", 1'b0);
        finish_test("plru_victim", start);
    endtask

    task automatic way_invalidate();
        int start;
        start = err_count;
        inval_req(4'd7, 2'd2);
        read_req(4'd7, 20'h102, 2'd0);
        refill_req(4'd7, 20'h105, rand_line());
        read_req(4'd7, 20'h105, 2'd3);
        run_stream("invalidate", 1'b0);
        finish_test("invalidate", start);
    endtask

    task automatic stall_stream();
        int          start;
        logic [31:0] rnd;
        set_t        s;
        tag_t        t;
        start = err_count;
        for (int i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            s   = set_t'(rnd[5:4]);
            t   = tag_t'(20'h200 + rnd[8:6]);
            if (rnd[3:0] < 4'd6) begin
                read_req(s, t, rnd[10:9]);
            end else if (rnd[3:0] < 4'd11) begin
                write_req(s, t, rnd[10:9], word_t'($random(seed)), rnd[14:11]);
            end else if (rnd[3:0] < 4'd14 && find_way(s, t) < 0) begin
                refill_req(s, t, rand_line());
            end else if (rnd[3:0] < 4'd14) begin
                // Tag already present so a second copy would give two hits
                read_req(s, t, rnd[10:9]);
            end else begin
                inval_req(s, rnd[16:15]);
            end
        end
        run_stream("backpressure", 1'b1);
        for (int si = 0; si < 4; si++) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int j = 0; j < LINE_WORDS; j++) begin
                    if (m_valid[si][w]) begin
                        read_req(set_t'(si), m_tag[si][w], word_idx_t'(j));
                    end
                end
            end
        end
        run_stream("backpressure", 1'b0);
        finish_test("backpressure", start);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
        $display("Watchdog expired after %0d cycles, the DUT stopped answering",
                 WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        seed        = 32'hec80364e;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        req_valid_i = 1'b0;
        req_op_i    = OP_READ;
        req_set_i   = '0;
        req_tag_i   = '0;
        req_word_i  = '0;
        req_wdata_i = '0;
        req_be_i    = '0;
        req_way_i   = '0;
        req_line_i  = '0;
        rsp_ready_i = 1'b1;
        for (int s = 0; s < SETS; s++) begin
            m_valid[s] = '0;
            m_mru[s]   = '0;
        end
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        init_ready_miss();
        line_fill_readback();
        merge_write();
        victim_choice();
        way_invalidate();
        stall_stream();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* source/cache_memctrl.sv */
// Set-associative cache controller, valid/ready request and response channels
// req_ready_o stays low for SETS cycles after reset while tags are cleared

`timescale 1ns/1ps

module cache_memctrl (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    req_valid_i,
    input  memctrl_pkg::op_t        req_op_i,
    input  memctrl_pkg::set_t       req_set_i,
    input  memctrl_pkg::tag_t       req_tag_i,
    input  memctrl_pkg::word_idx_t  req_word_i,
    input  memctrl_pkg::word_t      req_wdata_i,
    input  memctrl_pkg::be_t        req_be_i,
    input  memctrl_pkg::way_idx_t   req_way_i,
    input  memctrl_pkg::line_t      req_line_i,
    output logic                    req_ready_o,
    output logic                    rsp_valid_o,
    output logic                    rsp_hit_o,
    output memctrl_pkg::way_vec_t   rsp_way_o,
    output memctrl_pkg::word_t      rsp_rdata_o,
    input  logic                    rsp_ready_i
);
    import memctrl_pkg::*;

    way_lines_t rd_lines;

    cache_req_if  u_req_if ();
    dir_result_if u_res_if ();
    data_wr_if    u_wr_if ();

    // Request fields straight from the ports
    assign u_req_if.op    = req_op_i;
    assign u_req_if.set   = req_set_i;
    assign u_req_if.tag   = req_tag_i;
    assign u_req_if.word  = req_word_i;
    assign u_req_if.wdata = req_wdata_i;
    assign u_req_if.be    = req_be_i;
    assign u_req_if.way   = req_way_i;
    assign u_req_if.line  = req_line_i;

    tag_directory u_tag_directory (
        .clk_i,
        .rst_ni,
        .req (u_req_if.dir),
        .res (u_res_if.dir)
    );

    data_store u_data_store (
        .clk_i,
        .rst_ni,
        .req        (u_req_if.data),
        .wr         (u_wr_if.data),
        .rd_lines_o (rd_lines)
    );

    rsp_combiner u_rsp_combiner (
        .clk_i,
        .rst_ni,
        .req         (u_req_if.combiner),
        .res         (u_res_if.combiner),
        .wr          (u_wr_if.combiner),
        .rd_lines_i  (rd_lines),
        .rsp_ready_i,
        .req_valid_i,
        .req_ready_o,
        .rsp_valid_o,
        .rsp_hit_o,
        .rsp_way_o,
        .rsp_rdata_o
    );

endmodule

/* source/rsp_combiner.sv */
// Stage-1 register and response build; one request in stage 1 at a time
// Data writes happen on the response handshake so a held response writes once

`timescale 1ns/1ps

module rsp_combiner (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    cache_req_if.combiner           req,
    dir_result_if.combiner          res,
    data_wr_if.combiner             wr,
    input  memctrl_pkg::way_lines_t rd_lines_i,
    input  logic                    rsp_ready_i,
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    output logic                    rsp_valid_o,
    output logic                    rsp_hit_o,
    output memctrl_pkg::way_vec_t   rsp_way_o,
    output memctrl_pkg::word_t      rsp_rdata_o
);
    import memctrl_pkg::*;

    logic      valid_q;
    op_t       op_q;
    set_t      set_q;
    word_idx_t word_q;
    word_t     wdata_q;
    be_t       be_q;
    line_t     line_q;
    logic      is_lookup;
    logic      is_fill;
    logic      any_hit;
    word_t     hit_word;
    line_t     byte_mask;

    // Stage 1 frees up in the same cycle it retires
    assign req_ready_o = res.init_done && (!valid_q || rsp_ready_i);
    assign req.accept  = req_valid_i && req_ready_o;
    assign res.retire  = valid_q && rsp_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            op_q    <= OP_READ;
        end else if (req.accept) begin
            valid_q <= 1'b1;
            op_q    <= req.op;
        end else if (res.retire) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req.accept) begin
            set_q   <= req.set;
            word_q  <= req.word;
            wdata_q <= req.wdata;
            be_q    <= req.be;
            line_q  <= req.line;
        end
    end

    assign is_lookup = (op_q == OP_READ) || (op_q == OP_WRITE);
    assign is_fill   = (op_q == OP_REFILL);
    assign any_hit   = |res.hit_way;

    // Hit way is one-hot, so OR-ing the selected words is enough
    always_comb begin
        hit_word = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (res.hit_way[w]) begin
                hit_word |= rd_lines_i[w][word_q];
            end
        end
    end

    always_comb begin
        byte_mask = '0;
        for (int b = 0; b < WORD_WIDTH / 8; b++) begin
            byte_mask[word_q][8*b +: 8] = {8{be_q[b]}};
        end
    end

    assign wr.we   = res.retire && (is_fill || ((op_q == OP_WRITE) && any_hit));
    assign wr.set  = set_q;
    assign wr.way  = is_fill ? res.sel_way : res.hit_way;
    assign wr.line = is_fill ? line_q : {LINE_WORDS{wdata_q}};
    assign wr.mask = is_fill ? '1 : byte_mask;

    assign rsp_valid_o = valid_q;
    assign rsp_hit_o   = is_lookup && any_hit;
    assign rsp_way_o   = is_lookup ? res.hit_way : res.sel_way;
    assign rsp_rdata_o = (op_q == OP_READ) ? hit_word : '0;

endmodule

/* source/data_store.sv */
// Data array, one entry holds the lines of all ways of a set
// A write in the cycle of a same-set read is merged into that read result

`timescale 1ns/1ps

module data_store (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    cache_req_if.data               req,
    data_wr_if.data                 wr,
    output memctrl_pkg::way_lines_t rd_lines_o
);
    import memctrl_pkg::*;

    way_lines_t sram_rd;
    way_lines_t wr_lines;
    way_lines_t wr_mask;
    way_lines_t byp_lines_q;
    way_lines_t byp_mask_q;
    logic       byp_q;

    // Place the line in every way, the mask picks the target
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            wr_lines[w] = wr.line;
            wr_mask[w]  = wr.way[w] ? wr.mask : '0;
        end
    end

    sram_1r1w #(
        .entry_t (way_lines_t),
        .DEPTH   (SETS)
    ) u_data_sram (
        .clk_i,
        .rst_ni,
        .rd_en_i   (req.accept),
        .rd_addr_i (req.set),
        .rd_data_o (sram_rd),
        .wr_en_i   (wr.we),
        .wr_addr_i (wr.set),
        .wr_data_i (wr_lines),
        .wr_mask_i (wr_mask)
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            byp_q <= 1'b0;
        end else if (req.accept) begin
            byp_q <= wr.we && (wr.set == req.set);
        end
    end

    always_ff @(posedge clk_i) begin
        if (req.accept && wr.we) begin
            byp_lines_q <= wr_lines;
            byp_mask_q  <= wr_mask;
        end
    end

    assign rd_lines_o = byp_q ? ((sram_rd & ~byp_mask_q) | (byp_lines_q & byp_mask_q)) : sram_rd;

endmodule

/* source/tag_directory.sv */
// Tag array with per-set valid bits; tags are cleared over SETS cycles after reset
// Refill and invalidate update the directory when accepted, hits are reported one cycle later

`timescale 1ns/1ps

module tag_directory (
    input  logic      clk_i,
    input  logic      rst_ni,
    cache_req_if.dir  req,
    dir_result_if.dir res
);
    import memctrl_pkg::*;

    // All tags of one set side by side
    typedef tag_t [WAYS-1:0] tag_ways_t;

    logic                init_done_q;
    set_t                init_set_q;
    way_vec_t [SETS-1:0] valid_q;
    set_t                set_q;
    tag_t                tag_q;
    logic                lookup_q;
    way_vec_t            sel_way_q;
    way_vec_t            hit_way;
    way_vec_t            victim;
    way_vec_t            inval_way;
    logic                is_refill;
    logic                is_inval;
    tag_ways_t           rd_tags;
    logic                tag_we;
    set_t                tag_waddr;
    tag_ways_t           tag_wdata;
    tag_ways_t           tag_wmask;

    assign is_refill = req.accept && (req.op == OP_REFILL);
    assign is_inval  = req.accept && (req.op == OP_INVAL);
    assign inval_way = way_vec_t'(1) << req.way;

    // Init walks all sets once, then hands the write port to refills
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_done_q <= 1'b0;
            init_set_q  <= '0;
        end else if (!init_done_q) begin
            init_set_q  <= init_set_q + 1'b1;
            init_done_q <= (init_set_q == set_t'(SETS - 1));
        end
    end

    always_comb begin
        if (!init_done_q) begin
            tag_we    = 1'b1;
            tag_waddr = init_set_q;
            tag_wdata = '0;
            tag_wmask = '1;
        end else begin
            tag_we    = is_refill;
            tag_waddr = req.set;
            tag_wdata = {WAYS{req.tag}};
            for (int w = 0; w < WAYS; w++) begin
                tag_wmask[w] = {TAG_WIDTH{victim[w]}};
            end
        end
    end

    sram_1r1w #(
        .entry_t (tag_ways_t),
        .DEPTH   (SETS)
    ) u_tag_sram (
        .clk_i,
        .rst_ni,
        .rd_en_i   (req.accept),
        .rd_addr_i (req.set),
        .rd_data_o (rd_tags),
        .wr_en_i   (tag_we),
        .wr_addr_i (tag_waddr),
        .wr_data_i (tag_wdata),
        .wr_mask_i (tag_wmask)
    );

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            lookup_q <= 1'b0;
        end else if (req.accept) begin
            lookup_q <= (req.op == OP_READ) || (req.op == OP_WRITE);
            if (is_refill) begin
                valid_q[req.set] <= valid_q[req.set] | victim;
            end
            if (is_inval) begin
                valid_q[req.set] <= valid_q[req.set] & ~inval_way;
            end
        end
    end

    // Lookup context for the stage-1 compare
    always_ff @(posedge clk_i) begin
        if (req.accept) begin
            set_q     <= req.set;
            tag_q     <= req.tag;
            sel_way_q <= is_refill ? victim : (is_inval ? inval_way : '0);
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_way[w] = valid_q[set_q][w] && (rd_tags[w] == tag_q);
        end
    end

    // Hits touch the MRU bits when their response leaves
    replacement_plru u_plru (
        .clk_i,
        .rst_ni,
        .updt_i       (res.retire && lookup_q && (|hit_way)),
        .updt_set_i   (set_q),
        .updt_way_i   (hit_way),
        .repl_set_i   (req.set),
        .repl_valid_i (valid_q[req.set]),
        .victim_way_o (victim),
        .repl_i       (is_refill)
    );

    assign res.hit_way   = hit_way;
    assign res.sel_way   = sel_way_q;
    assign res.init_done = init_done_q;

endmodule

/* source/replacement_plru.sv */
// MRU-bit pseudo-LRU, one bit per way and set
// A hit update and a refill to the same set in one cycle apply in that order

`timescale 1ns/1ps

module replacement_plru (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  updt_i,
    input  memctrl_pkg::set_t     updt_set_i,
    input  memctrl_pkg::way_vec_t updt_way_i,
    input  memctrl_pkg::set_t     repl_set_i,
    input  memctrl_pkg::way_vec_t repl_valid_i,
    output memctrl_pkg::way_vec_t victim_way_o,
    input  logic                  repl_i
);
    import memctrl_pkg::*;

    way_vec_t [SETS-1:0] mru_q;
    way_vec_t [SETS-1:0] mru_d;
    way_vec_t            mru_repl;
    way_vec_t            free_way;
    way_vec_t            old_way;

    // Set the touched bit, restart when all bits would be set
    function automatic way_vec_t mru_touch(way_vec_t bits, way_vec_t way);
        way_vec_t next;
        next = bits | way;
        if (&next) begin
            next = way;
        end
        return next;
    endfunction

    always_comb begin
        mru_repl = mru_q[repl_set_i];
        if (updt_i && (updt_set_i == repl_set_i)) begin
            mru_repl = mru_touch(mru_repl, updt_way_i);
        end
        // Walk down so the lowest index wins
        free_way = '0;
        old_way  = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!repl_valid_i[w]) begin
                free_way = way_vec_t'(1) << w;
            end
            if (!mru_repl[w]) begin
                old_way = way_vec_t'(1) << w;
            end
        end
    end

    assign victim_way_o = (|free_way) ? free_way : old_way;

    always_comb begin
        mru_d = mru_q;
        if (updt_i) begin
            mru_d[updt_set_i] = mru_touch(mru_q[updt_set_i], updt_way_i);
        end
        if (repl_i) begin
            mru_d[repl_set_i] = mru_touch(mru_repl, victim_way_o);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mru_q <= '0;
        end else begin
            mru_q <= mru_d;
        end
    end

endmodule

/* source/sram_1r1w.sv */
// One read, one write array; a read of the address being written returns old data
// Read output holds its value while no read is issued

`timescale 1ns/1ps

module sram_1r1w #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     rd_en_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    output entry_t                   rd_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  entry_t                   wr_data_i,
    input  entry_t                   wr_mask_i
);

    entry_t mem_q [DEPTH];

    // Bit-masked write, unmasked bits keep their value
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[wr_addr_i] <= (mem_q[wr_addr_i] & ~wr_mask_i) | (wr_data_i & wr_mask_i);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_data_o <= '0;
        end else if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

endmodule

/* source/memctrl_if.sv */
// Internal bundles between the controller parts
// accept and retire are single-cycle strobes from the response combiner

`timescale 1ns/1ps

// Request fields, valid on the accept cycle only
interface cache_req_if;
    import memctrl_pkg::*;

    op_t       op;
    set_t      set;
    tag_t      tag;
    word_idx_t word;
    word_t     wdata;
    be_t       be;
    way_idx_t  way;
    line_t     line;
    logic      accept;

    modport source   (output op, set, tag, word, wdata, be, way, line);
    modport combiner (input op, set, word, wdata, be, line, output accept);
    modport dir      (input op, set, tag, way, accept);
    modport data     (input set, accept);
endinterface

// Directory results towards the combiner
interface dir_result_if;
    import memctrl_pkg::*;

    way_vec_t hit_way;
    way_vec_t sel_way;
    logic     init_done;
    logic     retire;

    modport dir      (output hit_way, sel_way, init_done, input retire);
    modport combiner (input hit_way, sel_way, init_done, output retire);
endinterface

// Masked line write into the data array
interface data_wr_if;
    import memctrl_pkg::*;

    logic     we;
    set_t     set;
    way_vec_t way;
    line_t    line;
    line_t    mask;

    modport combiner (output we, set, way, line, mask);
    modport data     (input we, set, way, line, mask);
endinterface

/* source/memctrl_pkg.sv */
// Geometry and field types of the cache memory controller
// Widths are fixed by the localparams below and are not parameters of the modules

package memctrl_pkg;

    // Cache geometry
    localparam int unsigned SETS       = 16;
    localparam int unsigned WAYS       = 4;
    localparam int unsigned LINE_WORDS = 4;
    localparam int unsigned WORD_WIDTH = 32;
    localparam int unsigned TAG_WIDTH  = 20;

    // Request address fields
    typedef logic [$clog2(SETS)-1:0]       set_t;
    typedef logic [TAG_WIDTH-1:0]          tag_t;
    typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t;

    // Way selection, one-hot or index form
    typedef logic [WAYS-1:0]               way_vec_t;
    typedef logic [$clog2(WAYS)-1:0]       way_idx_t;

    // Data payloads
    typedef logic [WORD_WIDTH-1:0]         word_t;
    typedef logic [WORD_WIDTH/8-1:0]       be_t;
    typedef word_t [LINE_WORDS-1:0]        line_t;
    typedef line_t [WAYS-1:0]              way_lines_t;

    // Request operation
    typedef enum logic [1:0] {
        OP_READ   = 2'd0,
        OP_WRITE  = 2'd1,
        OP_REFILL = 2'd2,
        OP_INVAL  = 2'd3
    } op_t;

endpackage
